// ==== sramPkg.sv ====
`default_nettype none

package sramPkg;

	// Local SRAM decode, flag clear selects the memory
	typedef struct packed {
		logic regionFlag;
		logic [22:0] byteAddr;
	} localView_s;

	// Management decode on the top nibble
	typedef struct packed {
		logic [3:0] region;
		logic [19:0] byteOffset;
	} mgmtView_s;

	typedef union packed {
		localView_s localView;
		mgmtView_s mgmtView;
	} busAddr_u;

	typedef struct packed {
		logic writeEnable;
		logic readEnable;
		logic [3:0] byteSelect;
		logic [20:0] address; // Word address inside the target
		logic [31:0] writeData;
	} targetReq_s;

	typedef struct packed {
		logic [31:0] readData;
		logic busy;
	} targetResp_s;

	localparam logic [3:0] MgmtRegion = 4'h8;

	localparam logic [7:0] MgmtIdOffset = 8'd0;
	localparam logic [7:0] MgmtCountOffset = 8'd1;
	localparam logic [7:0] MgmtScratch0Offset = 8'd2;
	localparam logic [7:0] MgmtScratch1Offset = 8'd3;

	// Replace the selected bytes of a word
	function automatic logic [31:0] mergeBytes(
		input logic [31:0] oldWord,
		input logic [31:0] newWord,
		input logic [3:0] byteSel
	);
		logic [31:0] merged;
		merged = oldWord;
		for (int i = 0; i < 4; i++) begin
			if (byteSel[i]) begin
				merged[i*8 +: 8] = newWord[i*8 +: 8];
			end
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

// ==== busyTimer.sv ====
`default_nettype none

module busyTimer #(
	parameter int WaitCycles = 2
) (
	input wire logic wb_clk_i,
	input wire logic wb_rst_i,
	input wire logic start_i,
	output logic busy_o
);

	// Start cycle counts as the first wait cycle
	localparam int CountWidth = (WaitCycles > 1) ? $clog2(WaitCycles) : 1;
	localparam int LoadValue = (WaitCycles > 0) ? WaitCycles - 1 : 0;

	logic [CountWidth-1:0] count;
	logic startBusy;

	assign startBusy = start_i && (WaitCycles != 0);

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			count <= '0;
		end else if (start_i) begin
			count <= CountWidth'(LoadValue);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Busy in the same cycle as the start
	assign busy_o = startBusy || (count != '0);

endmodule

`default_nettype wire

// ==== localMemory.sv ====
`default_nettype none

module localMemory import sramPkg::*; #(
	parameter int MemWordAddrWidth = 10,
	parameter int MemWaitCycles = 2
) (
	input wire logic wb_clk_i,
	input wire logic wb_rst_i,
	input wire targetReq_s req_i,
	output targetResp_s resp_o
);

	localparam int Depth = 2 ** MemWordAddrWidth;

	logic [31:0] memArray [Depth];
	logic [MemWordAddrWidth-1:0] wordIndex;
	logic active;
	logic activeLast;
	logic startAccess;
	logic timerBusy;

	assign wordIndex = req_i.address[MemWordAddrWidth-1:0]; // Upper bits alias
	assign active = req_i.writeEnable || req_i.readEnable;

	// First cycle of an access
	assign startAccess = active && !activeLast;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			activeLast <= 1'b0;
		end else begin
			activeLast <= active;
		end
	end

	busyTimer #(
		.WaitCycles(MemWaitCycles)
	) waitTimer (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.start_i(startAccess),
		.busy_o(timerBusy)
	);

	always_ff @(posedge wb_clk_i) begin
		if (req_i.writeEnable && !timerBusy) begin
			memArray[wordIndex] <= mergeBytes(memArray[wordIndex], req_i.writeData,
				req_i.byteSelect);
		end
	end

	// Control samples this once busy drops
	always_comb begin
		resp_o.readData = memArray[wordIndex];
		resp_o.busy = timerBusy;
	end

endmodule

`default_nettype wire

// ==== managementRegisters.sv ====
`default_nettype none

module managementRegisters import sramPkg::*; #(
	parameter logic [3:0] CoreId = 4'h5
) (
	input wire logic wb_clk_i,
	input wire logic wb_rst_i,
	input wire targetReq_s req_i,
	output targetResp_s resp_o
);

	logic [31:0] accessCount;
	logic [31:0] countNext;
	logic [31:0] scratch0;
	logic [31:0] scratch1;
	logic [7:0] regOffset;
	logic active;

	// Only two offset bits decode, the rest alias
	assign regOffset = {6'b0, req_i.address[1:0]};
	assign active = req_i.writeEnable || req_i.readEnable;
	assign countNext = accessCount + 32'd1;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			accessCount <= '0;
			scratch0 <= '0;
			scratch1 <= '0;
		end else if (active) begin
			accessCount <= countNext; // One enable cycle per access
			if (req_i.writeEnable) begin
				case (regOffset)
					MgmtScratch0Offset: begin
						scratch0 <= mergeBytes(scratch0, req_i.writeData, req_i.byteSelect);
					end
					MgmtScratch1Offset: begin
						scratch1 <= mergeBytes(scratch1, req_i.writeData, req_i.byteSelect);
					end
					default: begin
						// ID and counter are read only
					end
				endcase
			end
		end
	end

	always_comb begin
		resp_o.busy = 1'b0;
		case (regOffset)
			MgmtIdOffset: resp_o.readData = {28'b0, CoreId};
			MgmtCountOffset: resp_o.readData = countNext; // Includes this read
			MgmtScratch0Offset: resp_o.readData = scratch0;
			MgmtScratch1Offset: resp_o.readData = scratch1;
			default: resp_o.readData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== wbSramControl.sv ====
`default_nettype none

module wbSramControl import sramPkg::*; (
	input wire logic wb_clk_i,
	input wire logic wb_rst_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [3:0] wb_sel_i,
	input wire logic [23:0] wb_adr_i,
	input wire logic [31:0] wb_dat_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_err_o,
	output logic [31:0] wb_dat_o,
	output targetReq_s memReq_o,
	output targetReq_s mgmtReq_o,
	input wire targetResp_s memResp_i,
	input wire targetResp_s mgmtResp_i
);

	typedef enum logic [1:0] {
		StIdle,
		StAccess,
		StError,
		StFinish
	} state_e;

	state_e state;
	busAddr_u reqAddr;
	busAddr_u curAddr;
	logic curWe;
	logic [3:0] curSel;
	logic [31:0] curData;
	logic selMem;
	logic selMgmt;
	logic hitMem;
	logic hitMgmt;
	logic capture;
	logic inAccess;
	logic targetBusy;
	logic [31:0] targetData;
	logic ack;
	logic err;
	logic [31:0] readData;

	assign reqAddr = wb_adr_i;
	assign hitMem = !reqAddr.localView.regionFlag;
	assign hitMgmt = reqAddr.mgmtView.region == MgmtRegion;
	assign capture = (state == StIdle) && wb_cyc_i && wb_stb_i;
	assign inAccess = state == StAccess;

	assign targetBusy = selMem ? memResp_i.busy : mgmtResp_i.busy;
	assign targetData = selMem ? memResp_i.readData : mgmtResp_i.readData;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= StIdle;
			ack <= 1'b0;
			err <= 1'b0;
			readData <= '0;
		end else begin
			ack <= 1'b0;
			err <= 1'b0;
			readData <= '0; // Data only valid with ack
			case (state)
				StIdle: begin
					if (capture) begin
						if (hitMem || hitMgmt) begin
							state <= StAccess;
						end else begin
							state <= StError;
							err <= 1'b1; // Neither target
						end
					end
				end
				StAccess: begin
					if (!targetBusy) begin
						state <= StFinish;
						ack <= 1'b1;
						if (!curWe) begin
							readData <= targetData;
						end
					end
				end
				StError: state <= StFinish;
				StFinish: state <= StIdle;
			endcase
		end
	end

	// Request held for the whole access
	always_ff @(posedge wb_clk_i) begin
		if (capture) begin
			curAddr <= reqAddr;
			curWe <= wb_we_i;
			curSel <= wb_sel_i;
			curData <= wb_dat_i;
			selMem <= hitMem;
			selMgmt <= hitMgmt;
		end
	end

	always_comb begin
		memReq_o.writeEnable = inAccess && selMem && curWe;
		memReq_o.readEnable = inAccess && selMem && !curWe;
		memReq_o.byteSelect = curSel;
		memReq_o.address = curAddr.localView.byteAddr[22:2];
		memReq_o.writeData = curData;

		mgmtReq_o.writeEnable = inAccess && selMgmt && curWe;
		mgmtReq_o.readEnable = inAccess && selMgmt && !curWe;
		mgmtReq_o.byteSelect = curSel;
		mgmtReq_o.address = 21'(curAddr.mgmtView.byteOffset[19:2]);
		mgmtReq_o.writeData = curData;
	end

	assign wb_ack_o = ack;
	assign wb_err_o = err;
	assign wb_stall_o = state != StIdle; // Includes the finish cycle
	assign wb_dat_o = readData;

endmodule

`default_nettype wire

// ==== wbSramInterface.sv ====
`default_nettype none

module wbSramInterface import sramPkg::*; #(
	parameter int MemWordAddrWidth = 10,
	parameter int MemWaitCycles = 2,
	parameter logic [3:0] CoreId = 4'h5
) (
	input wire logic wb_clk_i,
	input wire logic wb_rst_i,
	input wire logic wb_cyc_i,
	input wire logic wb_stb_i,
	input wire logic wb_we_i,
	input wire logic [3:0] wb_sel_i,
	input wire logic [23:0] wb_adr_i,
	input wire logic [31:0] wb_dat_i,
	output logic wb_ack_o,
	output logic wb_stall_o,
	output logic wb_err_o,
	output logic [31:0] wb_dat_o
);

	targetReq_s memReq;
	targetReq_s mgmtReq;
	targetResp_s memResp;
	targetResp_s mgmtResp;

	wbSramControl control (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_err_o(wb_err_o),
		.wb_dat_o(wb_dat_o),
		.memReq_o(memReq),
		.mgmtReq_o(mgmtReq),
		.memResp_i(memResp),
		.mgmtResp_i(mgmtResp)
	);

	// Lower half of the address space
	localMemory #(
		.MemWordAddrWidth(MemWordAddrWidth),
		.MemWaitCycles(MemWaitCycles)
	) memory (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.req_i(memReq),
		.resp_o(memResp)
	);

	managementRegisters #(
		.CoreId(CoreId)
	) management (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.req_i(mgmtReq),
		.resp_o(mgmtResp)
	);

endmodule

`default_nettype wire

// ==== tbAccessTable.svh ====
`ifndef TB_ACCESS_TABLE_SVH
`define TB_ACCESS_TABLE_SVH

// How a row is judged
localparam logic [1:0] KindData = 2'd0; // Ack, read data compared
localparam logic [1:0] KindCount = 2'd1; // Ack, data is the management tally
localparam logic [1:0] KindErr = 2'd2;

typedef struct packed {
	logic we;
	logic [3:0] sel;
	logic [23:0] adr;
	logic [31:0] dat;
	logic [1:0] kind;
	logic [31:0] expData;
} accessRow_s;

localparam int NumRows = 26;

// we, sel, address, write data, kind, expected read data
localparam accessRow_s AccessTable [NumRows] = '{
	'{1'b0, 4'hF, 24'h800000, 32'h0000_0000, KindData, {28'h0, CoreId}},
	// Local memory, full and partial words
	'{1'b1, 4'hF, 24'h000010, 32'h1122_3344, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h000010, 32'h0000_0000, KindData, 32'h1122_3344},
	'{1'b1, 4'h5, 24'h000010, 32'hAABB_CCDD, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h000010, 32'h0000_0000, KindData, 32'h11BB_33DD},
	'{1'b1, 4'hF, 24'h001014, 32'hCAFE_F00D, KindData, 32'h0000_0000}, // Word 0x405
	'{1'b0, 4'hF, 24'h000014, 32'h0000_0000, KindData, 32'hCAFE_F00D},
	'{1'b1, 4'hF, 24'h7FFFFC, 32'h0102_0304, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h000FFC, 32'h0000_0000, KindData, 32'h0102_0304},
	// Scratch registers
	'{1'b1, 4'hF, 24'h800008, 32'h1234_5678, KindData, 32'h0000_0000},
	'{1'b1, 4'h3, 24'h80000C, 32'hFFFF_ABCD, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800008, 32'h0000_0000, KindData, 32'h1234_5678},
	'{1'b0, 4'hF, 24'h80000C, 32'h0000_0000, KindData, 32'h0000_ABCD},
	'{1'b1, 4'h8, 24'h800008, 32'hEE00_0000, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800008, 32'h0000_0000, KindData, 32'hEE34_5678},
	// Read only words ignore writes
	'{1'b1, 4'hF, 24'h800000, 32'hFFFF_FFFF, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800000, 32'h0000_0000, KindData, {28'h0, CoreId}},
	'{1'b1, 4'hF, 24'h800004, 32'h0000_0000, KindData, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800004, 32'h0000_0000, KindCount, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800010, 32'h0000_0000, KindData, {28'h0, CoreId}}, // ID alias
	// Unmapped regions
	'{1'b1, 4'hF, 24'h900010, 32'hDEAD_BEEF, KindErr, 32'h0000_0000},
	'{1'b1, 4'hF, 24'hF00008, 32'hDEAD_BEEF, KindErr, 32'h0000_0000},
	'{1'b0, 4'hF, 24'hA00000, 32'h0000_0000, KindErr, 32'h0000_0000},
	'{1'b0, 4'hF, 24'h800008, 32'h0000_0000, KindData, 32'hEE34_5678},
	'{1'b0, 4'hF, 24'h000010, 32'h0000_0000, KindData, 32'h11BB_33DD},
	'{1'b0, 4'hF, 24'h800004, 32'h0000_0000, KindCount, 32'h0000_0000}
};

`endif

// ==== tbSramInterface.sv ====
`default_nettype none

module tbSramInterface;

	localparam int MemWordAddrWidth = 10;
	localparam int MemWaitCycles = 2;
	localparam logic [3:0] CoreId = 4'h5;
	localparam int ClockPeriod = 40;
	localparam int RandomCount = 200;
	localparam int MemDepth = 2 ** MemWordAddrWidth;
	localparam int ResponseLimit = MemWaitCycles + 20;
	localparam logic [31:0] Seed = 32'h837c_8622;
	localparam int RegionMem = 0;
	localparam int RegionMgmt = 1;
	localparam int RegionNone = 2;

	`include "tbAccessTable.svh"

	localparam int WatchdogTime = (NumRows + RandomCount) * (MemWaitCycles + 8) * ClockPeriod;
	// Random addresses cover 16 words with random upper bits for aliasing
	localparam logic [31:0] ClearBits = ((1 << (MemWordAddrWidth + 2)) - 1) & ~32'h3f;
	localparam logic [22:0] PoolMask = 23'(~ClearBits);

	logic wb_clk_i;
	logic wb_rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [3:0] wb_sel_i;
	logic [23:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic wb_ack_o;
	logic wb_stall_o;
	logic wb_err_o;
	logic [31:0] wb_dat_o;

	logic [7:0] refMem [MemDepth*4];
	bit refValid [MemDepth*4];
	int errorCount;
	int checkCount;
	int mgmtTally;

	wbSramInterface #(
		.MemWordAddrWidth(MemWordAddrWidth),
		.MemWaitCycles(MemWaitCycles),
		.CoreId(CoreId)
	) uut (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_ack_o(wb_ack_o),
		.wb_stall_o(wb_stall_o),
		.wb_err_o(wb_err_o),
		.wb_dat_o(wb_dat_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #(ClockPeriod / 2) wb_clk_i = ~wb_clk_i;
	end

	initial begin
		#(WatchdogTime);
		$display("Watchdog expired before all accesses finished (%0d checks, %0d errors)",
			checkCount, errorCount);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("FAIL %s expected 0x%08h got 0x%08h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic reportProblem(input string what);
		errorCount++;
		$display("ERROR %s at %0t", what, $time);
	endtask

	function automatic int regionOf(input logic [23:0] adr);
		if (!adr[23]) return RegionMem;
		if (adr[23:20] == 4'h8) return RegionMgmt;
		return RegionNone;
	endfunction

	function automatic int expectedLatency(input logic [23:0] adr);
		case (regionOf(adr))
			RegionMem: return 2 + MemWaitCycles;
			RegionMgmt: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic int modelIndex(input logic [23:0] adr);
		return int'(adr[22:2]) % MemDepth; // Upper word bits alias
	endfunction

	task automatic modelWrite(input logic [23:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		int base;
		base = modelIndex(adr) * 4;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				refMem[base + b] = dat[b*8 +: 8];
				refValid[base + b] = 1'b1;
			end
		end
	endtask

	// Bytes never written are masked out
	task automatic modelRead(input logic [23:0] adr, output logic [31:0] data,
		output logic [31:0] mask);
		int base;
		base = modelIndex(adr) * 4;
		data = '0;
		mask = '0;
		for (int b = 0; b < 4; b++) begin
			if (refValid[base + b]) begin
				data[b*8 +: 8] = refMem[base + b];
				mask[b*8 +: 8] = 8'hFF;
			end
		end
	endtask

	task automatic runAccess(input logic we, input logic [3:0] sel, input logic [23:0] adr,
		input logic [31:0] dat, output logic gotAck, output logic gotErr,
		output logic [31:0] readData, output int latency);
		int waitCycles;
		logic responded;
		gotAck = 1'b0;
		gotErr = 1'b0;
		readData = '0;
		responded = 1'b0;
		waitCycles = 0;
		@(negedge wb_clk_i);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_sel_i = sel;
		wb_adr_i = adr;
		wb_dat_i = dat;
		while (wb_stall_o && waitCycles < ResponseLimit) begin
			@(negedge wb_clk_i);
			waitCycles++;
		end
		assert (!wb_stall_o) else reportProblem("stall stayed high, strobe never taken");
		@(negedge wb_clk_i);
		wb_stb_i = 1'b0; // Sampled at the last rising edge
		latency = 1;
		while (!responded && latency <= ResponseLimit) begin
			checkValue("wb_stall_o", 32'd1, {31'b0, wb_stall_o});
			if (wb_ack_o || wb_err_o) begin
				responded = 1'b1;
				gotAck = wb_ack_o;
				gotErr = wb_err_o;
				readData = wb_dat_o;
			end else begin
				checkValue("wb_dat_o", 32'd0, wb_dat_o);
				@(negedge wb_clk_i);
				latency++;
			end
		end
		wb_cyc_i = 1'b0;
		assert (responded) else reportProblem("no ack or err came back for the access");
		if (responded) begin
			checkValue("wb_ack_o & wb_err_o", 32'd0, {31'b0, wb_ack_o & wb_err_o});
			// Error state adds a cycle before finish
			if (gotErr) begin
				@(negedge wb_clk_i);
				checkValue("wb_stall_o", 32'd1, {31'b0, wb_stall_o});
			end
			@(negedge wb_clk_i);
			checkValue("wb_stall_o", 32'd0, {31'b0, wb_stall_o});
			checkValue("wb_ack_o", 32'd0, {31'b0, wb_ack_o});
			checkValue("wb_err_o", 32'd0, {31'b0, wb_err_o});
			checkValue("wb_dat_o", 32'd0, wb_dat_o);
		end
	endtask

	task automatic runTable();
		accessRow_s row;
		logic gotAck;
		logic gotErr;
		logic [31:0] readData;
		logic [31:0] expData;
		int latency;
		for (int i = 0; i < NumRows; i++) begin
			row = AccessTable[i];
			runAccess(row.we, row.sel, row.adr, row.dat, gotAck, gotErr, readData, latency);
			if (row.kind != KindErr && regionOf(row.adr) == RegionMgmt) begin
				mgmtTally++; // Counter includes this access
			end
			checkValue("wb_ack_o", {31'b0, row.kind != KindErr}, {31'b0, gotAck});
			checkValue("wb_err_o", {31'b0, row.kind == KindErr}, {31'b0, gotErr});
			checkValue("ack latency", 32'(expectedLatency(row.adr)), 32'(latency));
			expData = (row.kind == KindCount) ? 32'(mgmtTally) : row.expData;
			checkValue("wb_dat_o", expData, readData); // Zero alongside err
			if (row.kind != KindErr && row.we && regionOf(row.adr) == RegionMem) begin
				modelWrite(row.adr, row.sel, row.dat);
			end
		end
	endtask

	task automatic runRandom();
		logic [31:0] rnd;
		logic [31:0] ctl;
		logic [31:0] dat;
		logic [23:0] adr;
		logic gotAck;
		logic gotErr;
		logic [31:0] readData;
		logic [31:0] expData;
		logic [31:0] mask;
		int latency;
		for (int n = 0; n < RandomCount; n++) begin
			rnd = $urandom;
			ctl = $urandom;
			dat = $urandom;
			adr = {1'b0, rnd[22:0] & PoolMask};
			runAccess(ctl[0], ctl[7:4], adr, dat, gotAck, gotErr, readData, latency);
			checkValue("wb_ack_o", 32'd1, {31'b0, gotAck});
			checkValue("ack latency", 32'(2 + MemWaitCycles), 32'(latency));
			if (ctl[0]) begin
				modelWrite(adr, ctl[7:4], dat);
				checkValue("wb_dat_o", 32'd0, readData);
			end else begin
				modelRead(adr, expData, mask);
				checkValue("wb_dat_o", expData & mask, readData & mask);
			end
		end
	endtask

	initial begin
		void'($urandom(Seed));
		errorCount = 0;
		checkCount = 0;
		mgmtTally = 0;
		for (int i = 0; i < MemDepth * 4; i++) begin
			refValid[i] = 1'b0;
		end
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'h0;
		wb_adr_i = 24'h0;
		wb_dat_i = 32'h0;
		repeat (3) @(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		checkValue("wb_ack_o", 32'd0, {31'b0, wb_ack_o});
		checkValue("wb_err_o", 32'd0, {31'b0, wb_err_o});
		checkValue("wb_stall_o", 32'd0, {31'b0, wb_stall_o});
		checkValue("wb_dat_o", 32'd0, wb_dat_o);
		runTable();
		runRandom();
		@(negedge wb_clk_i);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
sramPkg.sv
busyTimer.sv
localMemory.sv
managementRegisters.sv
wbSramControl.sv
wbSramInterface.sv
+incdir+.
tbSramInterface.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run, the log decides the result
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tbSramInterface -o simv > build.log 2>&1 \
	&& ./obj_dir/simv | tee sim.log \
	&& grep -qx "=== PASS ===" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }

exit 0
